// ==== common/soc_io_pkg.sv ====
// I/O block constants: clock and baud rates, register map, reset values
// data width typedefs and the live status struct read by the result stage
package soc_io_pkg;

    localparam int clk_freq_hz    = 1_000_000;
    localparam int baud_rate      = 100_000;
    localparam int ms_tick_cycles = clk_freq_hz / 1000;
    localparam int uart_div       = clk_freq_hz / baud_rate;   // clocks per bit
    localparam int spi_div_slow   = 8;                         // clocks per sclk half
    localparam int spi_div_fast   = 2;
    localparam int h_res          = 640;
    localparam int v_res          = 480;
    localparam int rx_fifo_depth  = 16;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [4:0]  reg_idx_t;   // word index inside the I/O window

    localparam word_t fb_addr_default = 32'h100_0000;

    localparam reg_idx_t reg_ms        = 5'd0;
    localparam reg_idx_t reg_led       = 5'd1;
    localparam reg_idx_t reg_uart_data = 5'd2;
    localparam reg_idx_t reg_uart_stat = 5'd3;
    localparam reg_idx_t reg_spi_data  = 5'd4;
    localparam reg_idx_t reg_spi_stat  = 5'd5;
    localparam reg_idx_t reg_res       = 5'd9;
    localparam reg_idx_t reg_fb_addr   = 5'd12;

    typedef struct packed {
        word_t ms_count;
        byte_t rx_data;    // last dequeued character
        logic  rx_ready;
        logic  tx_ready;
        word_t spi_rx;
        logic  spi_ready;
    } io_status_t;

endpackage

// ==== common/soc_bus_pkg.sv ====
// APB request and response structs
// register command passed from decode to the execute stage
package soc_bus_pkg;

    localparam int apb_addr_w = 7;   // byte address inside the I/O window

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [apb_addr_w-1:0]  paddr;
        soc_io_pkg::word_t      pwdata;
    } apb_req_t;

    typedef struct packed {
        soc_io_pkg::word_t prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic                 wr_en;     // one cycle, access phase only
        soc_io_pkg::reg_idx_t reg_idx;
        soc_io_pkg::word_t    wdata;
    } io_cmd_t;

endpackage

// ==== verilog/io_decode.sv ====
// APB decode: word index, write strobe and unmapped address flag
module io_decode (
    input  logic                  clk_cpu,
    input  logic                  rst_n,
    input  soc_bus_pkg::apb_req_t apb_i,
    output soc_bus_pkg::io_cmd_t  cmd_o,
    output soc_io_pkg::reg_idx_t  rd_idx_o,
    output logic                  addr_err_o
);
    import soc_io_pkg::*;

    reg_idx_t idx;
    logic     mapped;
    logic     setup_q;   // setup phase seen last cycle
    logic     access;

    assign idx    = apb_i.paddr[6:2];
    assign access = apb_i.psel && apb_i.penable && setup_q;

    always_comb begin
        case (idx)
            reg_ms, reg_led, reg_uart_data, reg_uart_stat,
            reg_spi_data, reg_spi_stat, reg_res, reg_fb_addr: mapped = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= apb_i.psel && !apb_i.penable;
        end
    end

    // strobe is live in the access phase, so the write lands on its closing edge
    assign cmd_o = '{
        wr_en:   access && apb_i.pwrite && mapped,
        reg_idx: idx,
        wdata:   apb_i.pwdata
    };

    assign rd_idx_o   = idx;
    assign addr_err_o = apb_i.psel && apb_i.penable && !mapped;

endmodule

// ==== uart/uart_tx.sv ====
// UART transmitter, 8N1, started by a write to the data register
module uart_tx (
    input  logic                 clk_cpu,
    input  logic                 rst_n,
    input  soc_bus_pkg::io_cmd_t cmd_i,
    output logic                 tx_o,
    output logic                 tx_ready_o
);
    import soc_io_pkg::*;

    localparam int               div_w    = $clog2(uart_div);
    localparam logic [div_w-1:0] div_last = div_w'(uart_div - 1);

    logic [9:0]       shreg;      // stop, data, start
    logic [div_w-1:0] baud_cnt;
    logic [3:0]       bit_cnt;
    logic             busy;
    logic             start;

    assign start      = cmd_i.wr_en && cmd_i.reg_idx == reg_uart_data && !busy;
    assign tx_o       = shreg[0];
    assign tx_ready_o = !busy;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            shreg    <= '1;        // line idles high
            baud_cnt <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b0;
        end else if (start) begin
            shreg    <= {1'b1, cmd_i.wdata[7:0], 1'b0};
            baud_cnt <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b1;
        end else if (busy) begin
            if (baud_cnt == div_last) begin
                baud_cnt <= '0;
                shreg    <= {1'b1, shreg[9:1]};   // ones fill behind the frame
                bit_cnt  <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;                 // stop bit done
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== uart/uart_rx.sv ====
// UART receiver with mid-bit sampling
// completed characters go into a small receive FIFO
module uart_rx (
    input  logic              clk_cpu,
    input  logic              rst_n,
    input  logic              rx_i,
    input  logic              pop_i,
    output soc_io_pkg::byte_t head_o,
    output logic              empty_o
);
    import soc_io_pkg::*;

    localparam int               div_w    = $clog2(uart_div);
    localparam logic [div_w-1:0] div_last = div_w'(uart_div - 1);
    localparam logic [div_w-1:0] div_half = div_w'(uart_div / 2 - 1);
    localparam int               ptr_w    = $clog2(rx_fifo_depth) + 1;

    logic [2:0]       rx_sync;    // two sync flops plus previous value
    logic             rx_s;
    logic             rx_fall;
    logic             busy;
    logic [div_w-1:0] baud_cnt;
    logic [3:0]       bit_cnt;    // 0 start, 1..8 data, 9 stop
    logic             sample;
    byte_t            shreg;
    logic             push;
    byte_t            fifo_mem [rx_fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             full;

    assign rx_s    = rx_sync[1];
    assign rx_fall = rx_sync[2] && !rx_sync[1];
    assign sample  = busy && baud_cnt == '0;
    assign push    = sample && bit_cnt == 4'd9 && rx_s && !full;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            rx_sync <= '1;
        end else begin
            rx_sync <= {rx_sync[1:0], rx_i};
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (rx_fall) begin
                busy     <= 1'b1;
                baud_cnt <= div_half;   // first sample near mid start bit
                bit_cnt  <= '0;
            end
        end else if (sample) begin
            baud_cnt <= div_last;
            bit_cnt  <= bit_cnt + 4'd1;
            if ((bit_cnt == 4'd0 && rx_s) || bit_cnt == 4'd9) begin
                busy <= 1'b0;           // glitch on start, or frame done
            end
        end else begin
            baud_cnt <= baud_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (sample && bit_cnt != 4'd0 && bit_cnt != 4'd9) begin
            shreg <= {rx_s, shreg[7:1]};   // lsb arrives first
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (push) begin
            fifo_mem[wr_ptr[ptr_w-2:0]] <= shreg;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i && !empty_o) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign empty_o = wr_ptr == rd_ptr;
    assign full    = wr_ptr[ptr_w-1] != rd_ptr[ptr_w-1]
                     && wr_ptr[ptr_w-2:0] == rd_ptr[ptr_w-2:0];
    assign head_o  = fifo_mem[rd_ptr[ptr_w-2:0]];

endmodule

// ==== verilog/spi_master.sv ====
// SPI master, 32-bit transfers MSB first, slow and fast sclk rates
module spi_master (
    input  logic                 clk_cpu,
    input  logic                 rst_n,
    input  soc_bus_pkg::io_cmd_t cmd_i,
    input  logic                 fast_i,
    input  logic                 miso_i,
    output logic                 sclk_o,
    output logic                 mosi_o,
    output soc_io_pkg::word_t    rx_o,
    output logic                 ready_o
);
    import soc_io_pkg::*;

    localparam logic [2:0] half_slow = 3'(spi_div_slow - 1);
    localparam logic [2:0] half_fast = 3'(spi_div_fast - 1);

    word_t      shreg;       // tx bits leave at the top, rx bits enter at the bottom
    logic [2:0] half_cnt;
    logic [5:0] edge_cnt;    // 64 sclk edges per word
    logic       busy;
    logic       sclk_q;
    logic       miso_q;
    logic       start;
    logic       half_end;

    assign start    = cmd_i.wr_en && cmd_i.reg_idx == reg_spi_data && !busy;
    assign half_end = half_cnt == (fast_i ? half_fast : half_slow);

    assign sclk_o  = sclk_q;
    assign mosi_o  = shreg[31];
    assign rx_o    = shreg;
    assign ready_o = !busy;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            sclk_q   <= 1'b0;
            half_cnt <= '0;
            edge_cnt <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            sclk_q   <= 1'b0;
            half_cnt <= '0;
            edge_cnt <= '0;
        end else if (busy) begin
            if (half_end) begin
                half_cnt <= '0;
                sclk_q   <= !sclk_q;
                edge_cnt <= edge_cnt + 6'd1;
                if (edge_cnt == 6'd63) begin
                    busy <= 1'b0;       // last falling edge
                end
            end else begin
                half_cnt <= half_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (start) begin
            shreg <= cmd_i.wdata;
        end else if (busy && half_end) begin
            if (!sclk_q) begin
                miso_q <= miso_i;                   // rising edge sample
            end else begin
                shreg <= {shreg[30:0], miso_q};     // falling edge shift
            end
        end
    end

endmodule

// ==== verilog/io_regs.sv ====
// execute stage: LED, SPI control and framebuffer registers
// receive data dequeue and the millisecond counter
module io_regs (
    input  logic                 clk_cpu,
    input  logic                 rst_n,
    input  soc_bus_pkg::io_cmd_t cmd_i,
    input  soc_io_pkg::byte_t    fifo_head_i,
    input  logic                 fifo_empty_i,
    output logic                 fifo_pop_o,
    output soc_io_pkg::byte_t    led_o,
    output logic [1:0]           spi_cs_n_o,
    output logic                 spi_fast_o,
    output soc_io_pkg::word_t    fb_addr_o,
    output soc_io_pkg::byte_t    rx_data_o,
    output soc_io_pkg::word_t    ms_count_o
);
    import soc_io_pkg::*;

    localparam int                tick_w    = $clog2(ms_tick_cycles);
    localparam logic [tick_w-1:0] tick_last = tick_w'(ms_tick_cycles - 1);

    logic [2:0]        spi_ctrl;   // fast, cs1, cs0
    logic [tick_w-1:0] tick_cnt;
    logic              pop_q;

    assign spi_cs_n_o = ~spi_ctrl[1:0];   // active low selects
    assign spi_fast_o = spi_ctrl[2];
    assign fifo_pop_o = pop_q;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            led_o     <= '0;
            spi_ctrl  <= '0;
            fb_addr_o <= fb_addr_default;
            pop_q     <= 1'b0;
        end else begin
            pop_q <= cmd_i.wr_en && cmd_i.reg_idx == reg_uart_stat && !fifo_empty_i;
            if (cmd_i.wr_en) begin
                case (cmd_i.reg_idx)
                    reg_led:      led_o     <= cmd_i.wdata[7:0];
                    reg_spi_stat: spi_ctrl  <= cmd_i.wdata[2:0];
                    reg_fb_addr:  fb_addr_o <= cmd_i.wdata;
                    default: ;
                endcase
            end
        end
    end

    // head is taken in the same cycle the FIFO advances
    always_ff @(posedge clk_cpu) begin
        if (pop_q) begin
            rx_data_o <= fifo_head_i;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            tick_cnt   <= '0;
            ms_count_o <= '0;
        end else if (tick_cnt == tick_last) begin
            tick_cnt   <= '0;
            ms_count_o <= ms_count_o + 32'd1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

endmodule

// ==== verilog/io_result.sv ====
// read data multiplexer and APB response
module io_result (
    input  soc_io_pkg::reg_idx_t   rd_idx_i,
    input  logic                   addr_err_i,
    input  soc_io_pkg::io_status_t status_i,
    input  soc_io_pkg::byte_t      led_i,
    input  soc_io_pkg::word_t      fb_addr_i,
    output soc_bus_pkg::apb_rsp_t  rsp_o
);
    import soc_io_pkg::*;

    word_t rd_data;

    always_comb begin
        case (rd_idx_i)
            reg_ms:        rd_data = status_i.ms_count;
            reg_led:       rd_data = {24'd0, led_i};
            reg_uart_data: rd_data = {24'd0, status_i.rx_data};
            reg_uart_stat: rd_data = {30'd0, status_i.tx_ready, status_i.rx_ready};
            reg_spi_data:  rd_data = status_i.spi_rx;
            reg_spi_stat:  rd_data = {31'd0, status_i.spi_ready};
            reg_res:       rd_data = {16'(h_res), 16'(v_res)};
            reg_fb_addr:   rd_data = fb_addr_i;
            default:       rd_data = '0;   // unmapped reads return zero
        endcase
    end

    // no wait states, every transfer completes in its access phase
    assign rsp_o = '{
        prdata:  rd_data,
        pready:  1'b1,
        pslverr: addr_err_i
    };

endmodule

// ==== verilog/io_top.sv ====
// I/O block top: decode, execute and result stages with UART and SPI
module io_top (
    input  logic                  clk_cpu,
    input  logic                  rst_n,
    input  soc_bus_pkg::apb_req_t apb_i,
    output soc_bus_pkg::apb_rsp_t apb_o,
    output soc_io_pkg::byte_t     led_o,
    input  logic                  rx_i,
    output logic                  tx_o,
    input  logic                  spi_miso_i,
    output logic                  spi_sclk_o,
    output logic                  spi_mosi_o,
    output logic [1:0]            spi_cs_n_o
);
    import soc_io_pkg::*;
    import soc_bus_pkg::*;

    io_cmd_t    cmd;
    reg_idx_t   rd_idx;
    logic       addr_err;
    byte_t      fifo_head;
    logic       fifo_empty;
    logic       fifo_pop;
    logic       spi_fast;
    word_t      fb_addr;
    byte_t      rx_data;
    word_t      ms_count;
    logic       tx_ready;
    word_t      spi_rx;
    logic       spi_ready;
    io_status_t status;

    assign status = '{
        ms_count:  ms_count,
        rx_data:   rx_data,
        rx_ready:  !fifo_empty,
        tx_ready:  tx_ready,
        spi_rx:    spi_rx,
        spi_ready: spi_ready
    };

    io_decode u_decode (
        .clk_cpu(clk_cpu), .rst_n(rst_n), .apb_i(apb_i),
        .cmd_o(cmd), .rd_idx_o(rd_idx), .addr_err_o(addr_err)
    );

    io_regs u_regs (
        .clk_cpu(clk_cpu), .rst_n(rst_n), .cmd_i(cmd),
        .fifo_head_i(fifo_head), .fifo_empty_i(fifo_empty), .fifo_pop_o(fifo_pop),
        .led_o(led_o), .spi_cs_n_o(spi_cs_n_o), .spi_fast_o(spi_fast),
        .fb_addr_o(fb_addr), .rx_data_o(rx_data), .ms_count_o(ms_count)
    );

    uart_tx u_uart_tx (
        .clk_cpu(clk_cpu), .rst_n(rst_n), .cmd_i(cmd),
        .tx_o(tx_o), .tx_ready_o(tx_ready)
    );

    uart_rx u_uart_rx (
        .clk_cpu(clk_cpu), .rst_n(rst_n), .rx_i(rx_i),
        .pop_i(fifo_pop), .head_o(fifo_head), .empty_o(fifo_empty)
    );

    spi_master u_spi (
        .clk_cpu(clk_cpu), .rst_n(rst_n), .cmd_i(cmd), .fast_i(spi_fast),
        .miso_i(spi_miso_i), .sclk_o(spi_sclk_o), .mosi_o(spi_mosi_o),
        .rx_o(spi_rx), .ready_o(spi_ready)
    );

    io_result u_result (
        .rd_idx_i(rd_idx), .addr_err_i(addr_err), .status_i(status),
        .led_i(led_o), .fb_addr_i(fb_addr), .rsp_o(apb_o)
    );

endmodule

// ==== bench/io_top_asserts.sv ====
// concurrent checks on the APB response and on the idle UART and SPI lines
module io_top_asserts (
    input logic                  clk_cpu,
    input logic                  rst_n,
    input soc_bus_pkg::apb_req_t apb_req_i,
    input soc_bus_pkg::apb_rsp_t apb_rsp_i,
    input logic                  tx_i,
    input logic                  tx_ready_i,
    input logic                  sclk_i,
    input logic                  spi_ready_i
);

    pready_high: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        apb_rsp_i.pready) else $error("pready low");

    slverr_in_access: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        apb_rsp_i.pslverr |-> apb_req_i.penable && apb_rsp_i.prdata == '0)
        else $error("pslverr outside access phase or with nonzero read data");

    tx_idle_high: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        tx_ready_i |-> tx_i) else $error("tx line low while transmitter idle");

    sclk_idle_low: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        spi_ready_i |-> !sclk_i) else $error("sclk high while SPI idle");

endmodule

bind io_top io_top_asserts u_asserts (
    .clk_cpu(clk_cpu), .rst_n(rst_n), .apb_req_i(apb_i), .apb_rsp_i(apb_o),
    .tx_i(tx_o), .tx_ready_i(tx_ready), .sclk_i(spi_sclk_o), .spi_ready_i(spi_ready)
);

// ==== bench/tb_io_top.sv ====
// testbench for the I/O block: clock, reset, APB transfer and status poll tasks
// UART and SPI loopback, operations and expected values read from bench/io_cases.txt
module tb_io_top;
    import soc_io_pkg::*;
    import soc_bus_pkg::*;

    localparam int poll_limit = 400;   // status reads before giving up

    logic       clk_cpu;
    logic       rst_n;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    byte_t      led;
    wire        uart_line;   // tx looped back into rx
    wire        spi_line;    // mosi looped back into miso
    logic       sclk;
    logic [1:0] cs_n;
    int         sclk_high;   // clocks seen with sclk high
    int         errors;
    int         tests;
    int         passed;

    io_top dut0 (
        .clk_cpu(clk_cpu), .rst_n(rst_n), .apb_i(apb_req), .apb_o(apb_rsp),
        .led_o(led), .rx_i(uart_line), .tx_o(uart_line),
        .spi_miso_i(spi_line), .spi_sclk_o(sclk), .spi_mosi_o(spi_line),
        .spi_cs_n_o(cs_n)
    );

    initial clk_cpu = 1'b0;
    always #5 clk_cpu = !clk_cpu;

    always @(negedge clk_cpu) begin
        if (sclk === 1'b1) begin
            sclk_high++;
        end
    end

    // setup, access, idle; read data taken just after the access phase starts
    task automatic apb_xfer(input logic wr, input reg_idx_t idx, input word_t wdata,
                            output word_t rdata, output logic err);
        @(negedge clk_cpu);
        apb_req = '{
            psel:    1'b1,
            penable: 1'b0,
            pwrite:  wr,
            paddr:   {idx, 2'b00},
            pwdata:  wdata
        };
        @(negedge clk_cpu);
        apb_req.penable = 1'b1;
        #1;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk_cpu);
        apb_req = '0;
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    // reads a status word until the given bit is set
    task automatic poll_bit(input reg_idx_t idx, input int bit_no, input string what);
        word_t st;
        logic  err;
        int    n;
        st = '0;
        n  = 0;
        while (!st[bit_no] && n < poll_limit) begin
            apb_xfer(1'b0, idx, '0, st, err);
            n++;
        end
        if (!st[bit_no]) begin
            $display("timeout at t=%0t while waiting for %s", $time, what);
            errors++;
        end
    endtask

    task automatic run_case(input byte op, input word_t a, input word_t d, input word_t e);
        word_t      rd;
        word_t      rd2;
        logic       err;
        logic [1:0] cs_exp;
        int         sclk_exp;
        cs_exp   = ~a[1:0];   // selects are active low
        sclk_exp = 32 * (a[2] ? spi_div_fast : spi_div_slow);   // one high half per bit
        case (op)
            "R": begin
                apb_xfer(1'b0, a[4:0], '0, rd, err);
                if (rd !== e) report_mismatch("prdata", rd, e);
                if (err !== 1'b0) report_mismatch("pslverr", {31'd0, err}, 32'd0);
            end
            "W": apb_xfer(1'b1, a[4:0], d, rd, err);
            "L": if (led !== e[7:0]) report_mismatch("led_o", {24'd0, led}, e);
            "T": begin
                poll_bit(reg_uart_stat, 1, "uart tx ready");
                apb_xfer(1'b1, reg_uart_data, d, rd, err);
            end
            "U": begin
                poll_bit(reg_uart_stat, 0, "uart rx ready");
                apb_xfer(1'b1, reg_uart_stat, '0, rd, err);   // dequeue head
                apb_xfer(1'b0, reg_uart_data, '0, rd, err);
                if (rd !== e) report_mismatch("uart rx data", rd, e);
            end
            "S": begin
                apb_xfer(1'b1, reg_spi_stat, a, rd, err);
                sclk_high = 0;
                apb_xfer(1'b1, reg_spi_data, d, rd, err);
                poll_bit(reg_spi_stat, 0, "spi ready");
                apb_xfer(1'b0, reg_spi_data, '0, rd, err);
                if (rd !== e) report_mismatch("spi rx data", rd, e);
                if (cs_n !== cs_exp) begin
                    report_mismatch("spi_cs_n_o", {30'd0, cs_n}, {30'd0, cs_exp});
                end
                if (sclk_high != sclk_exp) begin
                    report_mismatch("spi_sclk_o high clocks", sclk_high, sclk_exp);
                end
            end
            "M": begin
                apb_xfer(1'b0, reg_ms, '0, rd, err);
                repeat (d * ms_tick_cycles) @(negedge clk_cpu);
                apb_xfer(1'b0, reg_ms, '0, rd2, err);
                if (rd2 - rd != d && rd2 - rd != d + 1) begin
                    $display("ERR t=%0t ms_count: moved by %0d, expected %0d or %0d",
                             $time, rd2 - rd, d, d + 1);
                    errors++;
                end
            end
            "E": begin
                apb_xfer(1'b0, a[4:0], '0, rd, err);
                if (rd !== e) report_mismatch("prdata", rd, e);
                if (err !== 1'b1) report_mismatch("pslverr", {31'd0, err}, 32'd1);
            end
            default: begin
                $display("unknown operation %c in the cases file", op);
                errors++;
            end
        endcase
    endtask

    initial begin
        int    fd;
        int    n;
        int    errs_before;
        string line;
        byte   op;
        word_t a;
        word_t d;
        word_t e;
        apb_req   = '0;
        rst_n     = 1'b0;
        sclk_high = 0;
        errors    = 0;
        tests     = 0;
        passed    = 0;
        repeat (10) @(negedge clk_cpu);
        rst_n = 1'b1;
        fd = $fopen("bench/io_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/io_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%c %h %h %h", op, a, d, e);
                    if (n == 4 && op != "#") begin
                        errs_before = errors;
                        run_case(op, a, d, e);
                        tests++;
                        if (errors == errs_before) begin
                            passed++;
                            $display("case %0d (%c) ok", tests, op);
                        end else begin
                            $display("case %0d (%c) failed", tests, op);
                        end
                    end
                end
            end
            $fclose(fd);
        end
        $display("%0d cases, %0d passed, %0d errors", tests, passed, errors);
        if (errors == 0 && tests > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/io_cases.txt ====
# op idx data expected, all hex; S puts the SPI control value in idx, M waits data ms
# R read, W write, L led pins, T uart send, U uart receive, S spi, M ms counter, E unmapped
R 01 00000000 00000000
R 0c 00000000 01000000
R 09 00000000 028001e0
R 03 00000000 00000002
R 05 00000000 00000001
W 01 000000a5 00000000
R 01 00000000 000000a5
L 00 00000000 000000a5
W 0c 20003000 00000000
R 0c 00000000 20003000
T 00 00000055 00000000
T 00 000000c3 00000000
T 00 00000000 00000000
U 00 00000000 00000055
U 00 00000000 000000c3
U 00 00000000 00000000
R 03 00000000 00000002
S 01 deadbeef deadbeef
S 06 12345678 12345678
M 00 00000002 00000000
E 07 00000000 00000000
W 07 ffffffff 00000000
R 01 00000000 000000a5
R 0c 00000000 20003000
L 00 00000000 000000a5

// ==== compile.f ====
common/soc_io_pkg.sv
common/soc_bus_pkg.sv
verilog/io_decode.sv
uart/uart_tx.sv
uart/uart_rx.sv
verilog/spi_master.sv
verilog/io_regs.sv
verilog/io_result.sv
verilog/io_top.sv
bench/io_top_asserts.sv
bench/tb_io_top.sv

// ==== Makefile ====
# Verilator simulation of the I/O block testbench
LOG = sim.log

sim:
	verilator --binary --timing --assert -f compile.f --top-module tb_io_top -o tb_io_top
	./obj_dir/tb_io_top > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
